// File: video_pkg.sv
package video_pkg;

	//////////////////////////////////////////////////////////////////////
	// Width types
	//////////////////////////////////////////////////////////////////////

	// Raster positions and active counts
	typedef logic [9:0] pix_cnt_t;

	// Dot colour index from the pattern stage
	typedef logic [7:0] color_idx_t;

	// One colour gun
	typedef logic [3:0] gun_t;

	//////////////////////////////////////////////////////////////////////
	// Raster defaults
	//////////////////////////////////////////////////////////////////////

	localparam int DEF_H_ACTIVE = 288;
	localparam int DEF_H_TOTAL  = 384;
	localparam int DEF_V_ACTIVE = 224;
	localparam int DEF_V_TOTAL  = 264;

	// 48 MHz master clock down to the 6 MHz dot rate
	localparam int DOT_DIV = 8;

	// Test pattern accumulator increments
	localparam logic [15:0] LSB_STEP = 16'd228;
	localparam logic [15:0] MSB_STEP = 16'd590;

	// Fixed palette in place of the colour PROM
	// Result packed as {red, green, blue}
	function automatic logic [11:0] color_of(input logic bank, input color_idx_t idx);
		gun_t red;
		gun_t green;
		gun_t blue;
		red   = idx[7:4];
		green = idx[3:0];
		// Upper bank shows the complement on blue
		blue  = (idx[7:4] ^ idx[3:0]) ^ {4{bank}};
		return {red, green, blue};
	endfunction

endpackage

// File: video_timing.sv
`timescale 1ns/1ps

module video_timing #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int H_TOTAL  = video_pkg::DEF_H_TOTAL,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
	parameter int V_TOTAL  = video_pkg::DEF_V_TOTAL
) (
	input  logic i_clk,
	input  logic i_rst,
	output logic o_pix_en,
	output logic o_h_sync_n,
	output logic o_v_sync_n,
	output logic o_h_blank_n,
	output logic o_v_blank_n,
	output logic o_comp_sync_n
);

	import video_pkg::*;

	// Sync windows follow the end of active video
	// Horizontal sync 8 dots after active, 16 dots wide
	localparam int HS_START = H_ACTIVE + 8;
	localparam int HS_END   = HS_START + 16;
	// Vertical sync 2 lines after active, 2 lines wide
	localparam int VS_START = V_ACTIVE + 2;
	localparam int VS_END   = VS_START + 2;

	localparam pix_cnt_t H_LAST = pix_cnt_t'(H_TOTAL - 1);
	localparam pix_cnt_t V_LAST = pix_cnt_t'(V_TOTAL - 1);

	logic [2:0] div_cnt;
	pix_cnt_t   h_cnt;
	pix_cnt_t   v_cnt;
	pix_cnt_t   h_next;
	pix_cnt_t   v_next;

	//////////////////////////////////////////////////////////////////////
	// Dot clock enable
	//////////////////////////////////////////////////////////////////////

	// One strobe on the last clock of each dot
	assign o_pix_en = (div_cnt == 3'(DOT_DIV - 1));

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			div_cnt <= '0;
		end else if (o_pix_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////////////////////////

	// Next dot position
	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_cnt == H_LAST) begin
			h_next = '0;
			// Line counter steps at end of line
			v_next = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end
	end

	// Levels compared on the next position
	// so they stay aligned with the counters
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			h_cnt       <= '0;
			v_cnt       <= '0;
			o_h_blank_n <= 1'b1;
			o_v_blank_n <= 1'b1;
			o_h_sync_n  <= 1'b1;
			o_v_sync_n  <= 1'b1;
		end else if (o_pix_en) begin
			h_cnt       <= h_next;
			v_cnt       <= v_next;
			o_h_blank_n <= (h_next < pix_cnt_t'(H_ACTIVE));
			o_v_blank_n <= (v_next < pix_cnt_t'(V_ACTIVE));
			o_h_sync_n  <= !((h_next >= pix_cnt_t'(HS_START)) &&
				(h_next < pix_cnt_t'(HS_END)));
			o_v_sync_n  <= !((v_next >= pix_cnt_t'(VS_START)) &&
				(v_next < pix_cnt_t'(VS_END)));
		end
	end

	// Composite sync, low on either pulse
	assign o_comp_sync_n = o_h_sync_n & o_v_sync_n;

endmodule

// File: active_counter.sv
`timescale 1ns/1ps

module active_counter #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_pix_en,
	input  logic              i_h_blank_n,
	input  logic              i_v_blank_n,
	output logic              o_active,
	output video_pkg::pix_cnt_t o_col,
	output video_pkg::pix_cnt_t o_row
);

	import video_pkg::*;

	localparam pix_cnt_t LAST_COL = pix_cnt_t'(H_ACTIVE - 1);
	localparam pix_cnt_t LAST_ROW = pix_cnt_t'(V_ACTIVE - 1);

	// Horizontal blank from the previous dot
	logic h_blank_q;
	logic h_fall;

	// End of an active line
	assign h_fall = h_blank_q & ~i_h_blank_n;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			h_blank_q <= 1'b0;
			o_active  <= 1'b0;
			o_col     <= '0;
			o_row     <= '0;
		end else if (i_pix_en) begin
			h_blank_q <= i_h_blank_n;
			o_active  <= i_h_blank_n & i_v_blank_n;

			// Column held at 0 through blank and on first dot
			if (!i_h_blank_n || !h_blank_q) begin
				o_col <= '0;
			end else if (o_col != LAST_COL) begin
				o_col <= o_col + 1'b1;
			end

			// Row held at 0 through vertical blank
			if (!i_v_blank_n) begin
				o_row <= '0;
			end else if (h_fall) begin
				o_row <= (o_row == LAST_ROW) ? '0 : o_row + 1'b1;
			end
		end
	end

endmodule

// File: dot_pattern.sv
`timescale 1ns/1ps

module dot_pattern #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE
) (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_pix_en,
	input  logic                    i_active,
	input  video_pkg::pix_cnt_t     i_col,
	input  video_pkg::pix_cnt_t     i_row,
	output video_pkg::color_idx_t   o_dot,
	output logic                    o_bank
);

	import video_pkg::*;

	localparam pix_cnt_t LAST_COL = pix_cnt_t'(H_ACTIVE - 1);
	// Rows where both accumulators restart
	localparam pix_cnt_t MID_CLR  = pix_cnt_t'(V_ACTIVE / 2 - 1);
	localparam pix_cnt_t LAST_ROW = pix_cnt_t'(V_ACTIVE - 1);
	// Palette bank switches here
	localparam pix_cnt_t MID_ROW  = pix_cnt_t'(V_ACTIVE / 2);

	logic [15:0] lsb_acc;
	logic [15:0] msb_acc;

	//////////////////////////////////////////////////////////////////////
	// Accumulators and dot index
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lsb_acc <= '0;
			msb_acc <= '0;
			o_dot   <= '0;
		end else if (i_pix_en) begin
			if (i_active) begin
				// Index from the accumulator tops
				o_dot <= {msb_acc[15:13], lsb_acc[15:11]};

				if ((i_row == MID_CLR) || (i_row == LAST_ROW)) begin
					// Row clear wins over both steps
					lsb_acc <= '0;
					msb_acc <= '0;
				end else if (i_col == LAST_COL) begin
					// Line wrap
					lsb_acc <= '0;
					msb_acc <= msb_acc + MSB_STEP;
				end else begin
					lsb_acc <= lsb_acc + LSB_STEP;
				end
			end else begin
				o_dot <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Palette bank
	//////////////////////////////////////////////////////////////////////

	// Upper bank for the lower half of the screen
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_bank <= 1'b0;
		end else if (i_pix_en) begin
			if (i_row == MID_ROW) begin
				o_bank <= 1'b1;
			end else if (i_row == '0) begin
				o_bank <= 1'b0;
			end
		end
	end

endmodule

// File: color_lookup.sv
`timescale 1ns/1ps

module color_lookup (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_pix_en,
	input  logic                  i_active,
	input  logic                  i_bank,
	input  logic                  i_comp_sync_n,
	input  video_pkg::color_idx_t i_dot,
	output video_pkg::gun_t       o_red,
	output video_pkg::gun_t       o_green,
	output video_pkg::gun_t       o_blue,
	output logic                  o_sync_n
);

	import video_pkg::*;

	// Active flag lined up with the dot index
	logic active_q;
	// First sync delay stage
	logic sync_q;
	// Palette output for the current dot
	logic [11:0] rgb;

	assign rgb = color_of(i_bank, i_dot);

	//////////////////////////////////////////////////////////////////////
	// Colour output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			active_q <= 1'b0;
			o_red    <= '0;
			o_green  <= '0;
			o_blue   <= '0;
		end else if (i_pix_en) begin
			active_q <= i_active;
			if (active_q) begin
				o_red   <= rgb[11:8];
				o_green <= rgb[7:4];
				o_blue  <= rgb[3:0];
			end else begin
				// Black in blanking
				o_red   <= '0;
				o_green <= '0;
				o_blue  <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sync delay line
	//////////////////////////////////////////////////////////////////////

	// Two dots, one for the pattern stage and one for this one
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sync_q   <= 1'b1;
			o_sync_n <= 1'b1;
		end else if (i_pix_en) begin
			sync_q   <= i_comp_sync_n;
			o_sync_n <= sync_q;
		end
	end

endmodule

// File: video_board.sv
`timescale 1ns/1ps

module video_board #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int H_TOTAL  = video_pkg::DEF_H_TOTAL,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
	parameter int V_TOTAL  = video_pkg::DEF_V_TOTAL
) (
	input  logic                i_clk,
	input  logic                i_rst,
	output logic                o_pix_en,
	output logic                o_hsync_n,
	output logic                o_vsync_n,
	output logic                o_hblank_n,
	output logic                o_vblank_n,
	output logic                o_sync_n,
	output logic                o_active,
	output video_pkg::pix_cnt_t o_col,
	output video_pkg::pix_cnt_t o_row,
	output video_pkg::gun_t     o_red,
	output video_pkg::gun_t     o_green,
	output video_pkg::gun_t     o_blue
);

	import video_pkg::*;

	logic       comp_sync_n;
	color_idx_t dot;
	logic       bank;

	// Raster position
	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) u_video_timing (
		.i_clk(i_clk), .i_rst(i_rst), .o_pix_en(o_pix_en),
		.o_h_sync_n(o_hsync_n), .o_v_sync_n(o_vsync_n),
		.o_h_blank_n(o_hblank_n), .o_v_blank_n(o_vblank_n),
		.o_comp_sync_n(comp_sync_n)
	);

	active_counter #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_active_counter (
		.i_clk(i_clk), .i_rst(i_rst), .i_pix_en(o_pix_en),
		.i_h_blank_n(o_hblank_n), .i_v_blank_n(o_vblank_n),
		.o_active(o_active), .o_col(o_col), .o_row(o_row)
	);

	// Test dots in place of tiles and sprites
	dot_pattern #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_dot_pattern (
		.i_clk(i_clk), .i_rst(i_rst), .i_pix_en(o_pix_en), .i_active(o_active),
		.i_col(o_col), .i_row(o_row), .o_dot(dot), .o_bank(bank)
	);

	// RGB out with matching sync
	color_lookup u_color_lookup (
		.i_clk(i_clk), .i_rst(i_rst), .i_pix_en(o_pix_en), .i_active(o_active),
		.i_bank(bank), .i_comp_sync_n(comp_sync_n), .i_dot(dot),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue), .o_sync_n(o_sync_n)
	);

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic o_clk
);

	// Free running, starts low
	initial begin
		o_clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2.0) o_clk = ~o_clk;
	end

endmodule

// File: video_board_chk.sv
`timescale 1ns/1ps

module video_board_chk (
	input logic i_clk,
	input logic i_rst,
	input logic i_pix_en,
	input logic i_hsync_n,
	input logic i_vsync_n,
	input logic i_hblank_n,
	input logic i_vblank_n,
	input logic i_active
);

	//////////////////////////////////////////////////////////////////////
	// Raster relationships
	//////////////////////////////////////////////////////////////////////

	// Sync pulses start inside blanking
	hsync_in_blank: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(i_hsync_n) |-> !i_hblank_n)
		else $error("Horizontal sync fell outside horizontal blank");

	vsync_in_blank: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(i_vsync_n) |-> !i_vblank_n)
		else $error("Vertical sync fell outside vertical blank");

	// Vertical blank never falls inside an active line
	active_in_frame: assert property (@(posedge i_clk) disable iff (i_rst)
		i_active |-> i_vblank_n)
		else $error("Active flag high while vertical blank was low");

	// A line of active dots opens with both blanks high
	active_starts_open: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_active) |-> (i_hblank_n && i_vblank_n))
		else $error("Active flag rose while a blank was low");

	// Single clock strobe
	pix_en_single: assert property (@(posedge i_clk) disable iff (i_rst)
		i_pix_en |=> !i_pix_en)
		else $error("Pixel enable high on two clocks in a row");

endmodule

// File: tb_video_board.sv
`timescale 1ns/1ps

module tb_video_board;

	import video_pkg::*;

	// Small raster, 16 of 32 dots and 8 of 14 lines
	localparam int H_ACT = 16;
	localparam int H_TOT = 32;
	localparam int V_ACT = 8;
	localparam int V_TOT = 14;
	localparam pix_cnt_t COL_END = pix_cnt_t'(H_ACT);
	localparam pix_cnt_t ROW_END = pix_cnt_t'(V_ACT);
	// Four frames worth of clocks
	localparam int WAIT_LIMIT = 4 * H_TOT * V_TOT * DOT_DIV;

	// One table point: frame, row, column, reset first
	typedef struct packed {
		logic [3:0] frame;
		pix_cnt_t   row;
		pix_cnt_t   col;
		logic       rst_before;
	} point_t;

	logic     clk;
	logic     rst;
	logic     pix_en;
	logic     hsync_n;
	logic     vsync_n;
	logic     hblank_n;
	logic     vblank_n;
	logic     sync_n;
	logic     active;
	pix_cnt_t col;
	pix_cnt_t row;
	gun_t     red;
	gun_t     green;
	gun_t     blue;

	point_t points[$];
	int     error_count;
	int     frame_no;
	logic   vblank_q;
	// Monitor state, sync and active delay lines
	int     gap;
	logic   sync_d1;
	logic   sync_exp;
	logic   act_d1;
	logic   act_d2;
	// Raster position model, current dot and the one before
	int     h_pos;
	int     v_pos;
	int     h_prev;
	int     v_prev;

	tb_clock #(.PERIOD_NS(4.0)) u_tb_clock (.o_clk(clk));

	video_board #(
		.H_ACTIVE(H_ACT), .H_TOTAL(H_TOT), .V_ACTIVE(V_ACT), .V_TOTAL(V_TOT)
	) i_video_board (
		.i_clk(clk), .i_rst(rst), .o_pix_en(pix_en),
		.o_hsync_n(hsync_n), .o_vsync_n(vsync_n),
		.o_hblank_n(hblank_n), .o_vblank_n(vblank_n),
		.o_sync_n(sync_n), .o_active(active), .o_col(col), .o_row(row),
		.o_red(red), .o_green(green), .o_blue(blue)
	);

	bind video_board video_board_chk u_video_board_chk (
		.i_clk(i_clk), .i_rst(i_rst), .i_pix_en(o_pix_en),
		.i_hsync_n(o_hsync_n), .i_vsync_n(o_vsync_n),
		.i_hblank_n(o_hblank_n), .i_vblank_n(o_vblank_n), .i_active(o_active)
	);

	task automatic report_fail(input string msg);
		error_count++;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic add_point(input int f, input int r, input int c, input logic rst_first);
		point_t p;
		p.frame      = 4'(f);
		p.row        = pix_cnt_t'(r);
		p.col        = pix_cnt_t'(c);
		p.rst_before = rst_first;
		points.push_back(p);
	endtask

	// Dot index of one active position, walking the frame in scan order
	function automatic color_idx_t model_dot(input int tgt_row, input int tgt_col);
		logic [15:0] lsb;
		logic [15:0] msb;
		color_idx_t  dot;
		lsb = '0;
		msb = '0;
		dot = '0;
		for (int r = 0; r < V_ACT; r++) begin
			for (int c = 0; c < H_ACT; c++) begin
				if (r == tgt_row && c == tgt_col) begin
					dot = {msb[15:13], lsb[15:11]};
				end
				// Mid and last row clears take priority
				if (r == V_ACT / 2 - 1 || r == V_ACT - 1) begin
					lsb = '0;
					msb = '0;
				end else if (c == H_ACT - 1) begin
					lsb = '0;
					msb = msb + MSB_STEP;
				end else begin
					lsb = lsb + LSB_STEP;
				end
			end
		end
		return dot;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////////////////////////

	// Four clocks of reset, then idle outputs up to the first strobe
	task automatic apply_reset();
		int   n;
		logic done;
		n    = 0;
		done = 1'b0;
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		while (!done) begin
			@(negedge clk);
			assert (hsync_n && vsync_n && hblank_n && vblank_n && sync_n)
			else report_fail("Sync or blank output low right after reset");
			assert (!active) else report_fail("o_active high right after reset");
			assert ({red, green, blue} == 12'h000)
			else report_fail($sformatf("Mismatch o_red/o_green/o_blue: got %h %h %h expected 0 0 0",
				red, green, blue));
			done = pix_en;
			n++;
			if (!done && n > 2 * DOT_DIV) begin
				report_fail("Timeout waiting for the first pixel enable");
			end
		end
	endtask

	task automatic wait_point(input point_t p);
		int   n;
		logic found;
		n     = 0;
		found = 1'b0;
		while (!found) begin
			@(negedge clk);
			found = (frame_no == int'(p.frame)) && active && (row == p.row) && (col == p.col);
			n++;
			if (!found && n > WAIT_LIMIT) begin
				report_fail($sformatf("Timeout waiting for frame %0d row %0d col %0d",
					p.frame, p.row, p.col));
			end
		end
	endtask

	// Colours land two pixel enables after the position shows
	task automatic wait_enables();
		int cnt;
		int n;
		cnt = 0;
		n   = 0;
		while (cnt < 2) begin
			if (pix_en) begin
				cnt++;
			end
			@(negedge clk);
			n++;
			if (n > 4 * DOT_DIV) begin
				report_fail("Timeout waiting for two pixel enables");
			end
		end
	endtask

	task automatic check_colours(input point_t p);
		color_idx_t  dot;
		logic [11:0] rgb;
		dot = model_dot(int'(p.row), int'(p.col));
		// Upper bank from mid-screen down
		rgb = color_of(p.row >= pix_cnt_t'(V_ACT / 2), dot);
		assert (red == rgb[11:8])
		else report_fail($sformatf("Mismatch o_red at row %0d col %0d: got %h expected %h",
			p.row, p.col, red, rgb[11:8]));
		assert (green == rgb[7:4])
		else report_fail($sformatf("Mismatch o_green at row %0d col %0d: got %h expected %h",
			p.row, p.col, green, rgb[7:4]));
		assert (blue == rgb[3:0])
		else report_fail($sformatf("Mismatch o_blue at row %0d col %0d: got %h expected %h",
			p.row, p.col, blue, rgb[3:0]));
	endtask

	// Frame count since reset, steps when vertical blank ends
	always @(posedge clk) begin
		if (rst) begin
			frame_no <= 0;
			vblank_q <= 1'b1;
		end else begin
			vblank_q <= vblank_n;
			if (vblank_n && !vblank_q) begin
				frame_no <= frame_no + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Running monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst) begin
			gap      = 0;
			sync_d1  = 1'b1;
			sync_exp = 1'b1;
			act_d1   = 1'b0;
			act_d2   = 1'b0;
			h_pos    = 0;
			v_pos    = 0;
			h_prev   = H_TOT - 1;
			v_prev   = 0;
		end else begin
			gap++;
			assert (col < COL_END) else report_fail($sformatf("o_col out of range at %h", col));
			assert (row < ROW_END) else report_fail($sformatf("o_row out of range at %h", row));
			// Blank and sync levels of the current dot
			assert (hblank_n == (h_pos < H_ACT))
			else report_fail($sformatf("Mismatch o_hblank_n: got %h expected %h",
				hblank_n, h_pos < H_ACT));
			assert (vblank_n == (v_pos < V_ACT))
			else report_fail($sformatf("Mismatch o_vblank_n: got %h expected %h",
				vblank_n, v_pos < V_ACT));
			assert (hsync_n == !(h_pos >= H_ACT + 8 && h_pos < H_ACT + 24))
			else report_fail($sformatf("Mismatch o_hsync_n: got %h expected %h",
				hsync_n, !(h_pos >= H_ACT + 8 && h_pos < H_ACT + 24)));
			assert (vsync_n == !(v_pos >= V_ACT + 2 && v_pos < V_ACT + 4))
			else report_fail($sformatf("Mismatch o_vsync_n: got %h expected %h",
				vsync_n, !(v_pos >= V_ACT + 2 && v_pos < V_ACT + 4)));
			// Active flag and counts trail the raster by one dot
			assert (active == (h_prev < H_ACT && v_prev < V_ACT))
			else report_fail($sformatf("Mismatch o_active: got %h expected %h",
				active, h_prev < H_ACT && v_prev < V_ACT));
			if (active) begin
				assert (col == pix_cnt_t'(h_prev))
				else report_fail($sformatf("Mismatch o_col: got %h expected %h", col, h_prev));
				assert (row == pix_cnt_t'(v_prev))
				else report_fail($sformatf("Mismatch o_row: got %h expected %h", row, v_prev));
			end
			// Composite sync two dots late
			assert (sync_n == sync_exp)
			else report_fail($sformatf("Mismatch o_sync_n: got %h expected %h", sync_n, sync_exp));
			// Black whenever the dot two enables back was blanked
			if (!act_d2) begin
				assert ({red, green, blue} == 12'h000)
				else report_fail($sformatf(
					"Mismatch o_red/o_green/o_blue in blanking: got %h %h %h expected 0 0 0",
					red, green, blue));
			end
			if (pix_en) begin
				assert (gap == DOT_DIV)
				else report_fail($sformatf("Pixel enable came after %0d clocks, not 8", gap));
				gap      = 0;
				sync_exp = sync_d1;
				sync_d1  = hsync_n & vsync_n;
				act_d2   = act_d1;
				act_d1   = active;
				h_prev   = h_pos;
				v_prev   = v_pos;
				// Raster steps one dot
				if (h_pos == H_TOT - 1) begin
					h_pos = 0;
					v_pos = (v_pos == V_TOT - 1) ? 0 : v_pos + 1;
				end else begin
					h_pos++;
				end
			end
		end
	end

	initial begin
		rst         = 1'b1;
		error_count = 0;
		// Row 3 and 7 clears, column wrap, bank at row 4, mid-frame reset
		add_point(0, 0, 0, 1'b1);
		add_point(0, 0, 5, 1'b0);
		add_point(0, 0, 15, 1'b0);
		add_point(0, 1, 0, 1'b0);
		add_point(0, 2, 9, 1'b0);
		add_point(0, 3, 0, 1'b0);
		add_point(0, 3, 4, 1'b0);
		add_point(0, 4, 0, 1'b0);
		add_point(0, 4, 7, 1'b0);
		add_point(0, 5, 12, 1'b0);
		add_point(0, 6, 15, 1'b0);
		add_point(0, 7, 0, 1'b0);
		add_point(0, 7, 3, 1'b0);
		add_point(1, 0, 3, 1'b0);
		add_point(1, 2, 15, 1'b0);
		add_point(1, 5, 4, 1'b0);
		add_point(0, 3, 8, 1'b1);
		add_point(0, 4, 2, 1'b0);
		add_point(1, 1, 11, 1'b0);
		add_point(2, 6, 6, 1'b0);
		foreach (points[i]) begin
			if (points[i].rst_before) begin
				apply_reset();
			end
			wait_point(points[i]);
			wait_enables();
			check_colours(points[i]);
		end
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: files.f
video_pkg.sv
video_timing.sv
active_counter.sv
dot_pattern.sv
color_lookup.sv
video_board.sv
tb_clock.sv
video_board_chk.sv
tb_video_board.sv

// File: run.sh
#!/bin/sh
# Build the video board testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_board -f files.f \
	&& ./obj_dir/Vtb_video_board | tee /dev/stderr | grep -q "NO ERRORS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
